// File: source/vlsu_defines.svh
// Size macros for the vector register, memory word and element counts
`ifndef VLSU_DEFINES_SVH
`define VLSU_DEFINES_SVH

////////////////////////////////////////////////////////////
// Vector register
////////////////////////////////////////////////////////////

// Bits in one vector register
`define VLSU_VLEN 64

// Bytes in one vector register, also mask size and largest vl
`define VLSU_VLENB 8

////////////////////////////////////////////////////////////
// Memory side
////////////////////////////////////////////////////////////

// Address and data word width
`define VLSU_XLEN 32
`define VLSU_WORD_BYTES 4

// Element counts and indices, 0 up to VLENB
`define VLSU_COUNT_W 4

`endif

// File: source/vlsu_pkg.sv
// Shared enums and packed structs: operation, width, mode, state, command, beat, memory request
`default_nettype none

`include "vlsu_defines.svh"

package vlsu_pkg;

    typedef enum logic {
        VLOAD  = 1'b0,
        VSTORE = 1'b1
    } vlsu_op_e;

    // VLENB >> code gives the elements per register
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } vlsu_width_e;

    typedef enum logic {
        UNIT_STRIDED = 1'b0,
        STRIDED      = 1'b1
    } vlsu_mode_e;

    typedef enum logic [1:0] {
        VLSU_IDLE        = 2'd0,
        VLSU_FIRST_CYCLE = 2'd1,
        VLSU_EXEC        = 2'd2,
        VLSU_LAST_CYCLE  = 2'd3
    } vlsu_state_e;

    typedef struct packed {
        vlsu_op_e                 op;
        vlsu_width_e              width;
        vlsu_mode_e               mode;
        logic                     vm;
        logic [`VLSU_COUNT_W-1:0] vl;
        logic [`VLSU_XLEN-1:0]    base;
        logic [`VLSU_XLEN-1:0]    stride;
    } vlsu_cmd_t;

    // One beat: state plus the element slice it carries
    typedef struct packed {
        vlsu_state_e              state;
        logic [`VLSU_COUNT_W-1:0] first;
        logic [`VLSU_COUNT_W-1:0] count;
    } vlsu_beat_t;

    typedef struct packed {
        logic [`VLSU_XLEN-1:0]       address;
        logic                        read_enable;
        logic [`VLSU_WORD_BYTES-1:0] byte_enable;
        logic [`VLSU_XLEN-1:0]       write_data;
    } vlsu_mem_req_t;

endpackage

`default_nettype wire

// File: source/vlsu_control.sv
// Module vlsu_control: beat state machine, element counters and hold generation
`default_nettype none
`timescale 1ns/1ns

`include "vlsu_defines.svh"

module vlsu_control (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  start_i,
    input  vlsu_pkg::vlsu_cmd_t   cmd_i,
    input  logic                  load_busy_i,
    output vlsu_pkg::vlsu_beat_t  beat_o,
    output logic                  hold_o
);

    vlsu_pkg::vlsu_state_e    state_q;
    vlsu_pkg::vlsu_state_e    state_d;

    logic [`VLSU_COUNT_W-1:0] done_q;
    logic [`VLSU_COUNT_W-1:0] per_beat;
    logic [`VLSU_COUNT_W-1:0] remaining;
    logic [`VLSU_COUNT_W-1:0] beat_count;

    ////////////////////////////////////////////////////////////
    // Element accounting
    ////////////////////////////////////////////////////////////

    // Strided beats move a single element, unit-strided fill the word
    always_comb begin
        if (cmd_i.mode == vlsu_pkg::STRIDED) begin
            per_beat = `VLSU_COUNT_W'(1);
        end else begin
            per_beat = `VLSU_COUNT_W'(`VLSU_WORD_BYTES) >> cmd_i.width;
        end
    end

    assign remaining  = cmd_i.vl - done_q;
    assign beat_count = (remaining < per_beat) ? remaining : per_beat;

    ////////////////////////////////////////////////////////////
    // Beat FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            vlsu_pkg::VLSU_IDLE: begin
                if (start_i) begin
                    // Single beat transfers go straight to the last beat
                    if (remaining <= per_beat) begin
                        state_d = vlsu_pkg::VLSU_LAST_CYCLE;
                    end else begin
                        state_d = vlsu_pkg::VLSU_FIRST_CYCLE;
                    end
                end
            end
            vlsu_pkg::VLSU_FIRST_CYCLE, vlsu_pkg::VLSU_EXEC: begin
                // Last beat next if what is left after this one fits in one beat
                if (remaining <= (per_beat << 1)) begin
                    state_d = vlsu_pkg::VLSU_LAST_CYCLE;
                end else begin
                    state_d = vlsu_pkg::VLSU_EXEC;
                end
            end
            default: begin
                state_d = vlsu_pkg::VLSU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= vlsu_pkg::VLSU_IDLE;
            done_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == vlsu_pkg::VLSU_IDLE) begin
                done_q <= '0;
            end else begin
                done_q <= done_q + beat_count;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        beat_o.state = state_q;
        beat_o.first = done_q;
        beat_o.count = (state_q == vlsu_pkg::VLSU_IDLE) ? '0 : beat_count;
    end

    // Loads stay held one more cycle while stage 2 finishes
    assign hold_o = (state_q != vlsu_pkg::VLSU_IDLE) || load_busy_i;

endmodule

`default_nettype wire

// File: source/vlsu_address_gen.sv
// Module vlsu_address_gen: per-beat offset register and memory address
`default_nettype none
`timescale 1ns/1ns

`include "vlsu_defines.svh"

module vlsu_address_gen (
    input  logic                  clk,
    input  logic                  reset_n,
    input  vlsu_pkg::vlsu_cmd_t   cmd_i,
    input  vlsu_pkg::vlsu_beat_t  beat_i,
    output logic [`VLSU_XLEN-1:0] address_o
);

    // Byte distance from base for the current beat
    logic [`VLSU_XLEN-1:0] offset_q;

    ////////////////////////////////////////////////////////////
    // Offset register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            offset_q <= '0;
        end else if (beat_i.state == vlsu_pkg::VLSU_IDLE) begin
            // First beat always starts at the base
            offset_q <= '0;
        end else if (cmd_i.mode == vlsu_pkg::UNIT_STRIDED) begin
            offset_q <= offset_q + `VLSU_XLEN'(`VLSU_WORD_BYTES);
        end else begin
            offset_q <= offset_q + cmd_i.stride;
        end
    end

    ////////////////////////////////////////////////////////////
    // Address
    ////////////////////////////////////////////////////////////

    // Unit-strided base is word aligned, strided base element aligned
    assign address_o = cmd_i.base + offset_q;

endmodule

`default_nettype wire

// File: source/vlsu_store_path.sv
// Module vlsu_store_path: store byte enables and lane-steered write data
`default_nettype none
`timescale 1ns/1ns

`include "vlsu_defines.svh"

module vlsu_store_path (
    input  vlsu_pkg::vlsu_cmd_t          cmd_i,
    input  vlsu_pkg::vlsu_beat_t         beat_i,
    input  logic [1:0]                   address_i,
    input  logic [`VLSU_VLENB-1:0]       mask_i,
    input  logic [`VLSU_VLEN-1:0]        write_data_i,
    output logic [`VLSU_WORD_BYTES-1:0]  byte_enable_o,
    output logic [`VLSU_XLEN-1:0]        write_data_o
);

    localparam int byte_idx_w = $clog2(`VLSU_VLENB);

    logic       store_beat;
    logic [1:0] size_mask;

    assign store_beat = (beat_i.state != vlsu_pkg::VLSU_IDLE) && (cmd_i.op == vlsu_pkg::VSTORE);

    // Lane bits that lie inside one element
    always_comb begin
        unique case (cmd_i.width)
            vlsu_pkg::EW8:  size_mask = 2'b00;
            vlsu_pkg::EW16: size_mask = 2'b01;
            default:        size_mask = 2'b11;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Lane steering
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int lane = 0; lane < `VLSU_WORD_BYTES; lane++) begin
            logic [`VLSU_COUNT_W-1:0] elem;
            logic [`VLSU_COUNT_W-1:0] reg_byte;
            logic [1:0]               lane_bits;
            logic                     lane_hit;

            lane_bits = 2'(lane);
            if (cmd_i.mode == vlsu_pkg::UNIT_STRIDED) begin
                // Consecutive elements packed from lane 0 upward
                elem     = beat_i.first + (`VLSU_COUNT_W'(lane_bits) >> cmd_i.width);
                reg_byte = (beat_i.first << cmd_i.width) + `VLSU_COUNT_W'(lane_bits);
                lane_hit = 1'b1;
            end else begin
                // One element copied into every slot of the word
                elem     = beat_i.first;
                reg_byte = (beat_i.first << cmd_i.width)
                           + `VLSU_COUNT_W'(lane_bits & size_mask);
                lane_hit = ((lane_bits ^ address_i) & ~size_mask) == 2'b00;
            end

            byte_enable_o[lane] = store_beat && lane_hit && (elem < cmd_i.vl)
                                  && (cmd_i.vm || mask_i[elem[byte_idx_w-1:0]]);

            // Bytes past the register only land on disabled lanes
            write_data_o[8*lane +: 8] = write_data_i[8*reg_byte[byte_idx_w-1:0] +: 8];
        end
    end

endmodule

`default_nettype wire

// File: source/vlsu_load_path.sv
// Module vlsu_load_path: stage-2 registers and read word assembly into the register image
`default_nettype none
`timescale 1ns/1ns

`include "vlsu_defines.svh"

module vlsu_load_path (
    input  logic                  clk,
    input  logic                  reset_n,
    input  vlsu_pkg::vlsu_cmd_t   cmd_i,
    input  vlsu_pkg::vlsu_beat_t  beat_i,
    input  logic [1:0]            address_i,
    input  logic [`VLSU_XLEN-1:0] mem_read_data_i,
    output logic                  load_busy_o,
    output logic [`VLSU_VLEN-1:0] read_data_o
);

    vlsu_pkg::vlsu_beat_t  beat_q;
    logic [1:0]            address_q;
    logic                  load_beat_q;
    logic                  new_load;
    logic [`VLSU_VLEN-1:0] merged;

    ////////////////////////////////////////////////////////////
    // Stage 2 registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_q.state <= vlsu_pkg::VLSU_IDLE;
            beat_q.first <= '0;
            beat_q.count <= '0;
        end else begin
            beat_q <= beat_i;
        end
    end

    always_ff @(posedge clk) begin
        address_q <= address_i;
    end

    assign load_beat_q = (beat_q.state != vlsu_pkg::VLSU_IDLE) && (cmd_i.op == vlsu_pkg::VLOAD);
    assign load_busy_o = load_beat_q;

    // First load beat issuing while stage 2 is empty
    assign new_load = (beat_i.state != vlsu_pkg::VLSU_IDLE)
                      && (beat_q.state == vlsu_pkg::VLSU_IDLE)
                      && (cmd_i.op == vlsu_pkg::VLOAD);

    ////////////////////////////////////////////////////////////
    // Lane extraction and merge
    ////////////////////////////////////////////////////////////

    // The lane of register byte j is its distance from the beat's first byte,
    // moved up by the address low bits. Unit-strided words are aligned, so
    // only strided beats see a nonzero address_q
    always_comb begin
        merged = read_data_o;
        for (int j = 0; j < `VLSU_VLENB; j++) begin
            logic [`VLSU_COUNT_W-1:0] elem;
            logic [`VLSU_COUNT_W-1:0] rel;
            logic [1:0]               lane;

            elem = `VLSU_COUNT_W'(j) >> cmd_i.width;
            rel  = `VLSU_COUNT_W'(j) - (beat_q.first << cmd_i.width);
            lane = address_q + rel[1:0];
            if ((elem >= beat_q.first) && (elem < beat_q.first + beat_q.count)) begin
                merged[8*j +: 8] = mem_read_data_i[8*lane +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_data_o <= '0;
        end else if (new_load) begin
            // Elements above vl read back as zero
            read_data_o <= '0;
        end else if (load_beat_q) begin
            read_data_o <= merged;
        end
    end

endmodule

`default_nettype wire

// File: source/vlsu_top.sv
// Module vlsu_top: vector load/store unit top level with control, address, store and load paths
`default_nettype none
`timescale 1ns/1ns

`include "vlsu_defines.svh"

module vlsu_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  vlsu_pkg::vlsu_cmd_t     cmd_i,
    input  logic [`VLSU_VLENB-1:0]  mask_i,
    input  logic [`VLSU_VLEN-1:0]   write_data_i,
    input  logic                    start_i,
    output logic                    hold_o,
    output vlsu_pkg::vlsu_mem_req_t mem_req_o,
    input  logic [`VLSU_XLEN-1:0]   mem_read_data_i,
    output logic [`VLSU_VLEN-1:0]   read_data_o
);

    vlsu_pkg::vlsu_beat_t        beat;
    logic [`VLSU_XLEN-1:0]       address;
    logic [`VLSU_WORD_BYTES-1:0] byte_enable;
    logic [`VLSU_XLEN-1:0]       write_data;
    logic                        load_busy;

    ////////////////////////////////////////////////////////////
    // Stage 1
    ////////////////////////////////////////////////////////////

    vlsu_control u_control (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_i     (start_i),
        .cmd_i       (cmd_i),
        .load_busy_i (load_busy),
        .beat_o      (beat),
        .hold_o      (hold_o)
    );

    vlsu_address_gen u_address_gen (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_i     (cmd_i),
        .beat_i    (beat),
        .address_o (address)
    );

    vlsu_store_path u_store_path (
        .cmd_i         (cmd_i),
        .beat_i        (beat),
        .address_i     (address[1:0]),
        .mask_i        (mask_i),
        .write_data_i  (write_data_i),
        .byte_enable_o (byte_enable),
        .write_data_o  (write_data)
    );

    ////////////////////////////////////////////////////////////
    // Stage 2
    ////////////////////////////////////////////////////////////

    vlsu_load_path u_load_path (
        .clk             (clk),
        .reset_n         (reset_n),
        .cmd_i           (cmd_i),
        .beat_i          (beat),
        .address_i       (address[1:0]),
        .mem_read_data_i (mem_read_data_i),
        .load_busy_o     (load_busy),
        .read_data_o     (read_data_o)
    );

    // Memory request, read only on load beats
    always_comb begin
        mem_req_o.address     = address;
        mem_req_o.read_enable = (beat.state != vlsu_pkg::VLSU_IDLE)
                                && (cmd_i.op == vlsu_pkg::VLOAD);
        mem_req_o.byte_enable = byte_enable;
        mem_req_o.write_data  = write_data;
    end

endmodule

`default_nettype wire

// File: testbench/vlsu_memory_model.sv
// Module vlsu_memory_model: synchronous byte-enabled word memory with bulk load and contents view
`default_nettype none
`timescale 1ns/1ns

`include "vlsu_defines.svh"

module vlsu_memory_model #(
    parameter int words = 32
) (
    input  logic                            clk,
    input  vlsu_pkg::vlsu_mem_req_t         req_i,
    output logic [`VLSU_XLEN-1:0]           read_data_o,
    input  logic                            load_i,
    input  logic [words*`VLSU_XLEN-1:0]     load_contents_i,
    output logic [words*`VLSU_XLEN-1:0]     contents_o
);

    localparam int index_w = $clog2(words);

    logic [`VLSU_XLEN-1:0] mem_q [words];
    logic [index_w-1:0]    index;

    // Word address, byte lanes come from the low two bits
    assign index = req_i.address[index_w+1:2];

    always_ff @(posedge clk) begin
        if (load_i) begin
            for (int w = 0; w < words; w++) begin
                mem_q[w] <= load_contents_i[`VLSU_XLEN*w +: `VLSU_XLEN];
            end
        end else begin
            for (int b = 0; b < `VLSU_WORD_BYTES; b++) begin
                if (req_i.byte_enable[b]) begin
                    mem_q[index][8*b +: 8] <= req_i.write_data[8*b +: 8];
                end
            end
        end
        // Read data shows up in the cycle after the request
        if (req_i.read_enable) begin
            read_data_o <= mem_q[index];
        end
    end

    always_comb begin
        for (int w = 0; w < words; w++) begin
            contents_o[`VLSU_XLEN*w +: `VLSU_XLEN] = mem_q[w];
        end
    end

endmodule

`default_nettype wire

// File: testbench/vlsu_tb.sv
// Table-driven testbench with byte-array reference model, checks and timeout
`default_nettype none
`timescale 1ns/1ns

`include "vlsu_defines.svh"

module vlsu_tb;

    localparam int max_cases = 24;
    localparam int mem_words = 32;
    localparam int mem_bytes = mem_words * `VLSU_WORD_BYTES;

    // One table row with the command and its mask
    typedef struct packed {
        vlsu_pkg::vlsu_cmd_t    cmd;
        logic [`VLSU_VLENB-1:0] mask;
    } test_row_t;

    logic                            clk;
    logic                            reset_n;
    logic                            start;
    vlsu_pkg::vlsu_cmd_t             cmd;
    logic [`VLSU_VLENB-1:0]          mask;
    logic [`VLSU_VLEN-1:0]           write_data;
    logic                            hold;
    vlsu_pkg::vlsu_mem_req_t         mem_req;
    logic [`VLSU_XLEN-1:0]           mem_read_data;
    logic [`VLSU_VLEN-1:0]           read_data;
    logic                            mem_load;
    logic [mem_words*`VLSU_XLEN-1:0] mem_image;
    logic [mem_words*`VLSU_XLEN-1:0] mem_contents;

    test_row_t  rows [max_cases];
    int         num_rows;
    logic [7:0] ref_mem [mem_bytes];
    int         cycle_count;
    int         cycle_limit;

    vlsu_top u_dut (
        .clk             (clk),
        .reset_n         (reset_n),
        .cmd_i           (cmd),
        .mask_i          (mask),
        .write_data_i    (write_data),
        .start_i         (start),
        .hold_o          (hold),
        .mem_req_o       (mem_req),
        .mem_read_data_i (mem_read_data),
        .read_data_o     (read_data)
    );

    vlsu_memory_model #(.words(mem_words)) u_memory (
        .clk             (clk),
        .req_i           (mem_req),
        .read_data_o     (mem_read_data),
        .load_i          (mem_load),
        .load_contents_i (mem_image),
        .contents_o      (mem_contents)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the test loop did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic int elem_bytes(input test_row_t row);
        return 1 << int'(row.cmd.width);
    endfunction

    // Unit-strided beats fill a word and strided beats carry one element
    function automatic int beat_total(input test_row_t row);
        int per;
        per = (row.cmd.mode == vlsu_pkg::STRIDED) ? 1 : `VLSU_WORD_BYTES / elem_bytes(row);
        return (int'(row.cmd.vl) + per - 1) / per;
    endfunction

    function automatic int elem_address(input test_row_t row, input int k);
        if (row.cmd.mode == vlsu_pkg::STRIDED) begin
            return int'(row.cmd.base) + k * int'(row.cmd.stride);
        end
        return int'(row.cmd.base) + k * elem_bytes(row);
    endfunction

    function automatic logic [`VLSU_VLEN-1:0] expected_image(input test_row_t row);
        logic [`VLSU_VLEN-1:0] image;
        int                    eb;
        image = '0;
        eb    = elem_bytes(row);
        for (int k = 0; k < int'(row.cmd.vl); k++) begin
            for (int b = 0; b < eb; b++) begin
                image[8*(k*eb+b) +: 8] = ref_mem[elem_address(row, k) + b];
            end
        end
        return image;
    endfunction

    task automatic apply_store(input test_row_t row, input logic [`VLSU_VLEN-1:0] data);
        int eb;
        eb = elem_bytes(row);
        for (int k = 0; k < int'(row.cmd.vl); k++) begin
            if (row.cmd.vm || row.mask[k]) begin
                for (int b = 0; b < eb; b++) begin
                    ref_mem[elem_address(row, k) + b] = data[8*(k*eb+b) +: 8];
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checks and stimulus
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_memory(input string name);
        logic [`VLSU_XLEN-1:0] expected;
        for (int w = 0; w < mem_words; w++) begin
            expected = {ref_mem[4*w+3], ref_mem[4*w+2], ref_mem[4*w+1], ref_mem[4*w]};
            check_value($sformatf("%s word %0d", name, w), 64'(expected),
                        64'(mem_contents[`VLSU_XLEN*w +: `VLSU_XLEN]));
        end
    endtask

    task automatic add_case(input int store, input int width, input int strided, input int base,
                            input int stride, input int vl, input int vm, input int row_mask);
        rows[num_rows].cmd.op     = (store != 0) ? vlsu_pkg::VSTORE : vlsu_pkg::VLOAD;
        rows[num_rows].cmd.width  = vlsu_pkg::vlsu_width_e'(2'(width));
        rows[num_rows].cmd.mode   = (strided != 0) ? vlsu_pkg::STRIDED : vlsu_pkg::UNIT_STRIDED;
        rows[num_rows].cmd.vm     = (vm != 0);
        rows[num_rows].cmd.vl     = 4'(vl);
        rows[num_rows].cmd.base   = 32'(base);
        rows[num_rows].cmd.stride = 32'(stride);
        rows[num_rows].mask       = 8'(row_mask);
        num_rows++;
    endtask

    // Start on a falling edge, then count hold cycles and watch the read enable
    task automatic run_case(input int idx);
        test_row_t             row;
        logic [`VLSU_VLEN-1:0] data;
        string                 name;
        int                    held;
        logic                  read_expected;
        row  = rows[idx];
        data = {$urandom, $urandom};
        name = $sformatf("case %0d %s %s %s", idx, row.cmd.op.name(), row.cmd.width.name(),
                         row.cmd.mode.name());
        @(negedge clk);
        cmd        = row.cmd;
        mask       = row.mask;
        write_data = data;
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        held  = 0;
        while (hold) begin
            // Read enable only on load beats and not in the stage-2 cycle
            read_expected = (row.cmd.op == vlsu_pkg::VLOAD) && (held < beat_total(row));
            check_value({name, " read enable"}, 64'(read_expected), 64'(mem_req.read_enable));
            held++;
            @(negedge clk);
        end
        if (row.cmd.op == vlsu_pkg::VSTORE) begin
            check_value({name, " hold cycles"}, 64'(beat_total(row)), 64'(held));
            apply_store(row, data);
            check_memory(name);
        end else begin
            check_value({name, " hold cycles"}, 64'(beat_total(row) + 1), 64'(held));
            check_value({name, " read data"}, expected_image(row), read_data);
        end
        // Idle gap before the next start
        repeat (2) @(negedge clk);
    endtask

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        start      = 1'b0;
        cmd        = '0;
        mask       = '0;
        write_data = '0;
        mem_load   = 1'b0;
        mem_image  = '0;
        num_rows   = 0;
        void'($urandom(47));

        //       st ew str base   stride vl vm mask
        add_case(0, 0, 0,  'h10,  0,     8, 1, 'h00);
        add_case(0, 0, 0,  'h20,  0,     5, 1, 'h00);
        add_case(0, 1, 0,  'h04,  0,     4, 1, 'h00);
        add_case(0, 1, 0,  'h08,  0,     3, 1, 'h00);
        add_case(0, 2, 0,  'h30,  0,     2, 1, 'h00);
        add_case(0, 2, 0,  'h0c,  0,     1, 1, 'h00);
        add_case(1, 0, 0,  'h40,  0,     7, 0, 'hb5);
        add_case(0, 0, 0,  'h40,  0,     8, 1, 'h00);
        add_case(1, 1, 0,  'h18,  0,     4, 1, 'h00);
        add_case(1, 1, 0,  'h28,  0,     3, 0, 'h06);
        add_case(1, 2, 0,  'h50,  0,     2, 0, 'h01);
        add_case(0, 0, 1,  'h03,  5,     8, 1, 'h00);
        add_case(0, 1, 1,  'h22,  6,     4, 1, 'h00);
        add_case(0, 2, 1,  'h44,  12,    2, 1, 'h00);
        add_case(1, 0, 1,  'h61,  3,     6, 0, 'h2d);
        add_case(1, 1, 1,  'h5a,  10,    4, 1, 'h00);
        add_case(1, 2, 1,  'h70,  8,     2, 1, 'h00);
        add_case(1, 0, 0,  'h7c,  0,     1, 1, 'h00);

        cycle_limit = 4 + 20;
        for (int i = 0; i < num_rows; i++) begin
            cycle_limit += beat_total(rows[i]) + 6;
        end

        for (int i = 0; i < mem_bytes; i++) begin
            ref_mem[i]          = 8'($urandom);
            mem_image[8*i +: 8] = ref_mem[i];
        end

        // Memory loaded while reset is still low
        @(negedge clk);
        mem_load = 1'b1;
        @(negedge clk);
        mem_load = 1'b0;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;

        @(negedge clk);
        check_value("reset hold", 64'd0, 64'(hold));
        check_value("reset read enable", 64'd0, 64'(mem_req.read_enable));
        check_value("reset byte enables", 64'd0, 64'(mem_req.byte_enable));
        check_value("reset read data", 64'd0, read_data);

        for (int i = 0; i < num_rows; i++) begin
            run_case(i);
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/vlsu_pkg.sv
source/vlsu_control.sv
source/vlsu_address_gen.sv
source/vlsu_store_path.sv
source/vlsu_load_path.sv
source/vlsu_top.sv
testbench/vlsu_memory_model.sv
testbench/vlsu_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ns --top-module vlsu_tb \
		-f project.f -Mdir obj_dir -o vlsu_sim
	./obj_dir/vlsu_sim | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
